/* verilog/id_settings.svh */
/*
  Widths and fixed constants of the RV32I decode stage.
  ID_XLEN and ID_INSN_W must stay at 32 for the RV32I encodings.
*/
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Data and address width
`define ID_XLEN 32
// Register file address width, 32 registers
`define ID_RADDR_W 5
// Instruction word width, no compressed forms
`define ID_INSN_W 32
// Return address increment for JAL/JALR
`define ID_LINK_INCR 4
// LSU access size encoding width
`define ID_LSU_TYPE_W 2

`endif

/* verilog/id_pkg.sv */
/*
  Enumerated types shared by the decode stage and its testbench.
  Encodings are local to this core and need not match any other ALU.
*/
`include "id_settings.svh"

package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // ALU and operand selects
  //////////////////////////////////////////////////////////////////////

  // Arithmetic, logic, shift and compare operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sra,
    alu_srl,
    alu_sll,
    alu_slt,
    alu_sltu,
    // Branch comparisons
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    op_a_reg_a,
    op_a_pc,
    op_a_zero
  } op_a_sel_e;

  typedef enum logic {
    op_b_reg_b,
    op_b_imm
  } op_b_sel_e;

  // Immediate routed to operand B, link is PC + 4
  typedef enum logic [2:0] {
    imm_sel_i,
    imm_sel_s,
    imm_sel_b,
    imm_sel_u,
    imm_sel_j,
    imm_sel_link
  } imm_b_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction and memory encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opc_load   = 7'h03,
    opc_op_imm = 7'h13,
    opc_auipc  = 7'h17,
    opc_store  = 7'h23,
    opc_op     = 7'h33,
    opc_lui    = 7'h37,
    opc_branch = 7'h63,
    opc_jalr   = 7'h67,
    opc_jal    = 7'h6f
  } opcode_e;

  typedef enum logic [`ID_LSU_TYPE_W-1:0] {
    lsu_word = 2'b00,
    lsu_half = 2'b01,
    lsu_byte = 2'b10
  } lsu_type_e;

endpackage

/* verilog/id_decoder.sv */
/*
  Combinational RV32I decoder. Enables are raw and not qualified by valid.
  Branch and jump operand selects depend on the first-cycle flag.
  Anything outside the RV32I base subset (no CSR, FENCE, ECALL) is illegal.
*/
`timescale 1ns/1ps
`include "id_settings.svh"

module id_decoder (
  input  logic [`ID_INSN_W-1:0]  instr_rdata_i,
  input  logic                   instr_first_cycle_i,
  output logic                   illegal_insn_o,
  output logic [`ID_RADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0] rf_raddr_b_o,
  output logic [`ID_RADDR_W-1:0] rf_waddr_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic                   rf_we_o,
  output id_pkg::alu_op_e        alu_operator_o,
  output id_pkg::op_a_sel_e      op_a_sel_o,
  output id_pkg::op_b_sel_e      op_b_sel_o,
  output id_pkg::imm_b_sel_e     imm_b_sel_o,
  output logic [`ID_XLEN-1:0]    imm_i_o,
  output logic [`ID_XLEN-1:0]    imm_s_o,
  output logic [`ID_XLEN-1:0]    imm_b_o,
  output logic [`ID_XLEN-1:0]    imm_u_o,
  output logic [`ID_XLEN-1:0]    imm_j_o,
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output logic                   lsu_sign_ext_o,
  output id_pkg::lsu_type_e      lsu_type_o,
  output logic                   branch_o,
  output logic                   jump_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////////////////////////////////////////////
  // Sign-extended immediates
  //////////////////////////////////////////////////////////////////////

  assign imm_i_o = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_o = {{(`ID_XLEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:25],
                    instr_rdata_i[11:7]};
  assign imm_b_o = {{(`ID_XLEN-13){instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                    instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  // U-type has no sign extension on RV32
  assign imm_u_o = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_o = {{(`ID_XLEN-21){instr_rdata_i[31]}}, instr_rdata_i[31],
                    instr_rdata_i[19:12], instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Default is an add of register A and the I-immediate, nothing enabled
    illegal_insn_o = 1'b0;
    rf_ren_a_o     = 1'b0;
    rf_ren_b_o     = 1'b0;
    rf_we_o        = 1'b0;
    alu_operator_o = id_pkg::alu_add;
    op_a_sel_o     = id_pkg::op_a_reg_a;
    op_b_sel_o     = id_pkg::op_b_imm;
    imm_b_sel_o    = id_pkg::imm_sel_i;
    lsu_req_o      = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_sign_ext_o = 1'b0;
    lsu_type_o     = id_pkg::lsu_word;
    branch_o       = 1'b0;
    jump_o         = 1'b0;

    case (id_pkg::opcode_e'(instr_rdata_i[6:0]))
      id_pkg::opc_lui: begin
        op_a_sel_o  = id_pkg::op_a_zero;
        imm_b_sel_o = id_pkg::imm_sel_u;
        rf_we_o     = 1'b1;
      end

      id_pkg::opc_auipc: begin
        op_a_sel_o  = id_pkg::op_a_pc;
        imm_b_sel_o = id_pkg::imm_sel_u;
        rf_we_o     = 1'b1;
      end

      // Target in the first cycle, link address in the second
      id_pkg::opc_jal: begin
        jump_o      = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = id_pkg::op_a_pc;
        imm_b_sel_o = instr_first_cycle_i ? id_pkg::imm_sel_j : id_pkg::imm_sel_link;
      end

      id_pkg::opc_jalr: begin
        jump_o         = 1'b1;
        rf_we_o        = 1'b1;
        rf_ren_a_o     = 1'b1;
        illegal_insn_o = (funct3 != 3'b000);
        if (!instr_first_cycle_i) begin
          op_a_sel_o  = id_pkg::op_a_pc;
          imm_b_sel_o = id_pkg::imm_sel_link;
        end
      end

      id_pkg::opc_branch: begin
        branch_o   = 1'b1;
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        case (funct3)
          3'b000:  alu_operator_o = id_pkg::alu_eq;
          3'b001:  alu_operator_o = id_pkg::alu_ne;
          3'b100:  alu_operator_o = id_pkg::alu_lt;
          3'b101:  alu_operator_o = id_pkg::alu_ge;
          3'b110:  alu_operator_o = id_pkg::alu_ltu;
          3'b111:  alu_operator_o = id_pkg::alu_geu;
          default: illegal_insn_o = 1'b1;
        endcase
        // Compare registers first, then PC + B-immediate for the target
        if (instr_first_cycle_i) begin
          op_b_sel_o = id_pkg::op_b_reg_b;
        end else begin
          alu_operator_o = id_pkg::alu_add;
          op_a_sel_o     = id_pkg::op_a_pc;
          imm_b_sel_o    = id_pkg::imm_sel_b;
        end
      end

      id_pkg::opc_load: begin
        lsu_req_o      = 1'b1;
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        // funct3[2] marks the unsigned variants
        lsu_sign_ext_o = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: lsu_type_o = id_pkg::lsu_byte;
          3'b001, 3'b101: lsu_type_o = id_pkg::lsu_half;
          3'b010:         lsu_type_o = id_pkg::lsu_word;
          default:        illegal_insn_o = 1'b1;
        endcase
      end

      id_pkg::opc_store: begin
        lsu_req_o   = 1'b1;
        lsu_we_o    = 1'b1;
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        imm_b_sel_o = id_pkg::imm_sel_s;
        case (funct3)
          3'b000:  lsu_type_o = id_pkg::lsu_byte;
          3'b001:  lsu_type_o = id_pkg::lsu_half;
          3'b010:  lsu_type_o = id_pkg::lsu_word;
          default: illegal_insn_o = 1'b1;
        endcase
      end

      id_pkg::opc_op_imm: begin
        rf_ren_a_o = 1'b1;
        rf_we_o    = 1'b1;
        case (funct3)
          3'b000: alu_operator_o = id_pkg::alu_add;
          3'b010: alu_operator_o = id_pkg::alu_slt;
          3'b011: alu_operator_o = id_pkg::alu_sltu;
          3'b100: alu_operator_o = id_pkg::alu_xor;
          3'b110: alu_operator_o = id_pkg::alu_or;
          3'b111: alu_operator_o = id_pkg::alu_and;
          3'b001: begin
            alu_operator_o = id_pkg::alu_sll;
            illegal_insn_o = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            if (funct7 == 7'b0000000) begin
              alu_operator_o = id_pkg::alu_srl;
            end else if (funct7 == 7'b0100000) begin
              alu_operator_o = id_pkg::alu_sra;
            end else begin
              illegal_insn_o = 1'b1;
            end
          end
        endcase
      end

      id_pkg::opc_op: begin
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        rf_we_o    = 1'b1;
        op_b_sel_o = id_pkg::op_b_reg_b;
        case ({funct7, funct3})
          10'b0000000_000: alu_operator_o = id_pkg::alu_add;
          10'b0100000_000: alu_operator_o = id_pkg::alu_sub;
          10'b0000000_001: alu_operator_o = id_pkg::alu_sll;
          10'b0000000_010: alu_operator_o = id_pkg::alu_slt;
          10'b0000000_011: alu_operator_o = id_pkg::alu_sltu;
          10'b0000000_100: alu_operator_o = id_pkg::alu_xor;
          10'b0000000_101: alu_operator_o = id_pkg::alu_srl;
          10'b0100000_101: alu_operator_o = id_pkg::alu_sra;
          10'b0000000_110: alu_operator_o = id_pkg::alu_or;
          10'b0000000_111: alu_operator_o = id_pkg::alu_and;
          default:         illegal_insn_o = 1'b1;
        endcase
      end

      default: illegal_insn_o = 1'b1;
    endcase
  end

endmodule

/* verilog/id_operand_mux.sv */
/*
  ALU operand muxing. Register data comes straight from the register file,
  there is no forwarding path.
*/
`timescale 1ns/1ps
`include "id_settings.svh"

module id_operand_mux (
  input  id_pkg::op_a_sel_e  op_a_sel_i,
  input  id_pkg::op_b_sel_e  op_b_sel_i,
  input  id_pkg::imm_b_sel_e imm_b_sel_i,
  input  logic [`ID_XLEN-1:0] imm_i_i,
  input  logic [`ID_XLEN-1:0] imm_s_i,
  input  logic [`ID_XLEN-1:0] imm_b_i,
  input  logic [`ID_XLEN-1:0] imm_u_i,
  input  logic [`ID_XLEN-1:0] imm_j_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o
);

  localparam logic [`ID_XLEN-1:0] link_incr = `ID_LINK_INCR;

  logic [`ID_XLEN-1:0] imm_b_sel;

  // Immediate for operand B
  always_comb begin
    case (imm_b_sel_i)
      id_pkg::imm_sel_i: imm_b_sel = imm_i_i;
      id_pkg::imm_sel_s: imm_b_sel = imm_s_i;
      id_pkg::imm_sel_b: imm_b_sel = imm_b_i;
      id_pkg::imm_sel_u: imm_b_sel = imm_u_i;
      id_pkg::imm_sel_j: imm_b_sel = imm_j_i;
      default:           imm_b_sel = link_incr;
    endcase
  end

  // Operand A, zero is used by LUI
  always_comb begin
    case (op_a_sel_i)
      id_pkg::op_a_reg_a: alu_operand_a_o = rf_rdata_a_i;
      id_pkg::op_a_pc:    alu_operand_a_o = pc_id_i;
      default:            alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel_i == id_pkg::op_b_imm) ? imm_b_sel : rf_rdata_b_i;

endmodule

/* verilog/id_ex_fsm.sv */
/*
  Stage state machine. Loads/stores wait for lsu_resp_valid_i, taken
  branches and jumps take two cycles. The IF side must hold the instruction
  stable until instr_done_o.
*/
`timescale 1ns/1ps

module id_ex_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic rf_we_dec_i,
  input  logic rf_ren_a_dec_i,
  input  logic rf_ren_b_dec_i,
  input  logic lsu_req_dec_i,
  input  logic branch_i,
  input  logic jump_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  output logic instr_first_cycle_o,
  output logic instr_done_o,
  output logic illegal_insn_o,
  output logic rf_we_o,
  output logic rf_ren_a_o,
  output logic rf_ren_b_o,
  output logic lsu_req_o,
  output logic pc_set_o
);

  typedef enum logic {
    fsm_first,
    fsm_multi
  } fsm_e;

  fsm_e state_q;
  fsm_e state_d;

  logic legal;
  logic stall_mem;
  logic stall_branch;
  logic stall_jump;
  logic stall;
  logic jump_set;
  logic branch_set_d;
  logic branch_set_q;

  // Only a valid, legal instruction may act
  assign legal = instr_valid_i & ~illegal_insn_i;

  assign instr_first_cycle_o = instr_valid_i & (state_q == fsm_first);

  //////////////////////////////////////////////////////////////////////
  // Next state and stalls
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = fsm_first;
    stall_mem    = 1'b0;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    jump_set     = 1'b0;
    branch_set_d = 1'b0;

    if (legal) begin
      case (state_q)
        fsm_first: begin
          if (lsu_req_dec_i) begin
            // Request cycle always stalls
            state_d   = fsm_multi;
            stall_mem = 1'b1;
          end else if (branch_i && branch_decision_i) begin
            // Taken branch, target computed next cycle
            state_d      = fsm_multi;
            stall_branch = 1'b1;
            branch_set_d = 1'b1;
          end else if (jump_i) begin
            // Target is on the operands now
            state_d    = fsm_multi;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end
        default: begin
          // Second cycle of branch/jump ends here, memory waits for response
          stall_mem = lsu_req_dec_i & ~lsu_resp_valid_i;
          state_d   = stall_mem ? fsm_multi : fsm_first;
        end
      endcase
    end
  end

  assign stall = stall_mem | stall_branch | stall_jump;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= fsm_first;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      branch_set_q <= branch_set_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Qualified outputs
  //////////////////////////////////////////////////////////////////////

  // Illegal words complete at once
  assign instr_done_o   = instr_valid_i & ~stall;
  assign illegal_insn_o = instr_valid_i & illegal_insn_i;

  // Write lands in the completing cycle only
  assign rf_we_o    = legal & rf_we_dec_i & ~stall;
  assign rf_ren_a_o = legal & rf_ren_a_dec_i;
  assign rf_ren_b_o = legal & rf_ren_b_dec_i;

  // One request per access, never repeated while waiting
  assign lsu_req_o = legal & lsu_req_dec_i & (state_q == fsm_first);

  // Jump sets at once, taken branch one cycle later
  assign pc_set_o = jump_set | branch_set_q;

endmodule

/* verilog/id_stage.sv */
/*
  RV32I decode stage top level. Register reads are combinational and the
  ALU result is written back by the consumer of rf_we_o and rf_waddr_o.
*/
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // IF side
  input  logic                   instr_valid_i,
  input  logic [`ID_INSN_W-1:0]  instr_rdata_i,
  input  logic [`ID_XLEN-1:0]    pc_id_i,
  output logic                   illegal_insn_o,
  output logic                   instr_done_o,
  output logic                   pc_set_o,
  // EX side
  input  logic                   branch_decision_i,
  input  logic                   lsu_resp_valid_i,
  output id_pkg::alu_op_e        alu_operator_o,
  output logic [`ID_XLEN-1:0]    alu_operand_a_o,
  output logic [`ID_XLEN-1:0]    alu_operand_b_o,
  // Register file
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  output logic [`ID_RADDR_W-1:0] rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0] rf_raddr_b_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic [`ID_RADDR_W-1:0] rf_waddr_o,
  output logic                   rf_we_o,
  // LSU
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output id_pkg::lsu_type_e      lsu_type_o,
  output logic                   lsu_sign_ext_o,
  output logic [`ID_XLEN-1:0]    lsu_wdata_o
);

  // Raw decoder controls
  logic illegal_insn_dec;
  logic rf_we_dec;
  logic rf_ren_a_dec;
  logic rf_ren_b_dec;
  logic lsu_req_dec;
  logic branch_dec;
  logic jump_dec;
  logic instr_first_cycle;

  id_pkg::op_a_sel_e  op_a_sel;
  id_pkg::op_b_sel_e  op_b_sel;
  id_pkg::imm_b_sel_e imm_b_sel;

  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  // Store data is register B as read
  assign lsu_wdata_o = rf_rdata_b_i;

  id_decoder u_decoder (
    .instr_rdata_i      (instr_rdata_i),
    .instr_first_cycle_i(instr_first_cycle),
    .illegal_insn_o     (illegal_insn_dec),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_waddr_o         (rf_waddr_o),
    .rf_ren_a_o         (rf_ren_a_dec),
    .rf_ren_b_o         (rf_ren_b_dec),
    .rf_we_o            (rf_we_dec),
    .alu_operator_o     (alu_operator_o),
    .op_a_sel_o         (op_a_sel),
    .op_b_sel_o         (op_b_sel),
    .imm_b_sel_o        (imm_b_sel),
    .imm_i_o            (imm_i),
    .imm_s_o            (imm_s),
    .imm_b_o            (imm_b),
    .imm_u_o            (imm_u),
    .imm_j_o            (imm_j),
    .lsu_req_o          (lsu_req_dec),
    .lsu_we_o           (lsu_we_o),
    .lsu_sign_ext_o     (lsu_sign_ext_o),
    .lsu_type_o         (lsu_type_o),
    .branch_o           (branch_dec),
    .jump_o             (jump_dec)
  );

  id_operand_mux u_operand_mux (
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .imm_i_i        (imm_i),
    .imm_s_i        (imm_s),
    .imm_b_i        (imm_b),
    .imm_u_i        (imm_u),
    .imm_j_i        (imm_j),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .pc_id_i        (pc_id_i),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  // Qualifies all enables with valid and legality
  id_ex_fsm u_ex_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_dec),
    .rf_we_dec_i        (rf_we_dec),
    .rf_ren_a_dec_i     (rf_ren_a_dec),
    .rf_ren_b_dec_i     (rf_ren_b_dec),
    .lsu_req_dec_i      (lsu_req_dec),
    .branch_i           (branch_dec),
    .jump_i             (jump_dec),
    .branch_decision_i  (branch_decision_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .instr_first_cycle_o(instr_first_cycle),
    .instr_done_o       (instr_done_o),
    .illegal_insn_o     (illegal_insn_o),
    .rf_we_o            (rf_we_o),
    .rf_ren_a_o         (rf_ren_a_o),
    .rf_ren_b_o         (rf_ren_b_o),
    .lsu_req_o          (lsu_req_o),
    .pc_set_o           (pc_set_o)
  );

endmodule

/* verification/tb_id_stage.sv */
/*
  Directed testbench for the decode stage. Inputs change on the rising edge
  and outputs are sampled on the falling edge. Register data is random.
*/
`timescale 1ns/1ps
`include "id_settings.svh"

module tb_id_stage;

  // Major opcodes of the RV32I subset
  localparam logic [6:0] opc_load   = 7'h03;
  localparam logic [6:0] opc_op_imm = 7'h13;
  localparam logic [6:0] opc_auipc  = 7'h17;
  localparam logic [6:0] opc_store  = 7'h23;
  localparam logic [6:0] opc_op     = 7'h33;
  localparam logic [6:0] opc_lui    = 7'h37;
  localparam logic [6:0] opc_branch = 7'h63;
  localparam logic [6:0] opc_jalr   = 7'h67;
  localparam logic [6:0] opc_jal    = 7'h6f;
  localparam int         reset_cycles = 16;
  localparam int         done_limit   = 20;

  logic clk;
  logic rst_n;
  logic instr_valid;
  logic [`ID_INSN_W-1:0] instr_rdata;
  logic [`ID_XLEN-1:0] pc_id;
  logic branch_decision;
  logic lsu_resp_valid;
  logic [`ID_XLEN-1:0] rf_rdata_a;
  logic [`ID_XLEN-1:0] rf_rdata_b;
  logic illegal_insn;
  logic instr_done;
  logic pc_set;
  id_pkg::alu_op_e alu_operator;
  logic [`ID_XLEN-1:0] alu_operand_a;
  logic [`ID_XLEN-1:0] alu_operand_b;
  logic [`ID_RADDR_W-1:0] rf_raddr_a;
  logic [`ID_RADDR_W-1:0] rf_raddr_b;
  logic rf_ren_a;
  logic rf_ren_b;
  logic [`ID_RADDR_W-1:0] rf_waddr;
  logic rf_we;
  logic lsu_req;
  logic lsu_we;
  id_pkg::lsu_type_e lsu_type;
  logic lsu_sign_ext;
  logic [`ID_XLEN-1:0] lsu_wdata;

  logic [31:0] rng_state;

  id_stage uut (
    .clk_i(clk), .rst_ni(rst_n),
    .instr_valid_i(instr_valid), .instr_rdata_i(instr_rdata), .pc_id_i(pc_id),
    .illegal_insn_o(illegal_insn), .instr_done_o(instr_done), .pc_set_o(pc_set),
    .branch_decision_i(branch_decision), .lsu_resp_valid_i(lsu_resp_valid),
    .alu_operator_o(alu_operator), .alu_operand_a_o(alu_operand_a),
    .alu_operand_b_o(alu_operand_b),
    .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
    .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
    .rf_ren_a_o(rf_ren_a), .rf_ren_b_o(rf_ren_b),
    .rf_waddr_o(rf_waddr), .rf_we_o(rf_we),
    .lsu_req_o(lsu_req), .lsu_we_o(lsu_we), .lsu_type_o(lsu_type),
    .lsu_sign_ext_o(lsu_sign_ext), .lsu_wdata_o(lsu_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 32-bit xorshift generator
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Instruction encoders per RV32I format
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(int imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(int imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(int imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(int imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input logic done, input logic we, input logic req,
                            input logic set, input logic ill);
    check_equal(instr_done, done, "instr_done_o");
    check_equal(rf_we, we, "rf_we_o");
    check_equal(lsu_req, req, "lsu_req_o");
    check_equal(pc_set, set, "pc_set_o");
    check_equal(illegal_insn, ill, "illegal_insn_o");
  endtask

  task automatic check_operands(input logic [31:0] a, input logic [31:0] b);
    check_equal(alu_operand_a, a, "alu_operand_a_o");
    check_equal(alu_operand_b, b, "alu_operand_b_o");
  endtask

  task automatic check_idle();
    check_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_equal(rf_ren_a, 1'b0, "rf_ren_a_o");
    check_equal(rf_ren_b, 1'b0, "rf_ren_b_o");
  endtask

  task automatic pick_operands(output logic [4:0] rs1, output logic [4:0] rs2,
                               output logic [4:0] rd, output logic [31:0] ra,
                               output logic [31:0] rb, output logic [31:0] pc);
    logic [31:0] r;
    r   = next_rand();
    rs1 = r[4:0];
    rs2 = r[9:5];
    rd  = r[14:10];
    ra  = next_rand();
    rb  = next_rand();
    r   = next_rand();
    pc  = {r[31:2], 2'b00};
  endtask

  // Presents one instruction and moves to the sampling point of its first cycle
  task automatic apply_instr(input logic [31:0] word, input logic [31:0] pc,
                             input logic [31:0] ra, input logic [31:0] rb, input logic taken);
    @(posedge clk);
    instr_valid     <= 1'b1;
    instr_rdata     <= word;
    pc_id           <= pc;
    rf_rdata_a      <= ra;
    rf_rdata_b      <= rb;
    branch_decision <= taken;
    lsu_resp_valid  <= 1'b0;
    @(negedge clk);
  endtask

  task automatic go_idle();
    @(posedge clk);
    instr_valid     <= 1'b0;
    branch_decision <= 1'b0;
    lsu_resp_valid  <= 1'b0;
    @(negedge clk);
    check_idle();
  endtask

  // Raises the LSU response after resp_delay extra cycles
  // A negative delay leaves it low
  task automatic wait_for_done(input int resp_delay, output int cycles);
    cycles = 0;
    while (instr_done !== 1'b1) begin
      if (cycles >= done_limit) begin
        $display("Timed out after %0d cycles waiting for instr_done_o", cycles);
        abort_run();
      end else begin
        @(posedge clk);
        if (cycles == resp_delay) begin
          lsu_resp_valid <= 1'b1;
        end
        @(negedge clk);
        cycles++;
        // A stalled access never repeats its request and never writes
        check_equal(lsu_req, 1'b0, "lsu_req_o after first cycle");
        if (instr_done !== 1'b1) begin
          check_equal(rf_we, 1'b0, "rf_we_o while stalled");
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reg_reg(input logic [6:0] f7, input logic [2:0] f3,
                              input id_pkg::alu_op_e op);
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    apply_instr(enc_r(f7, rs2, rs1, f3, rd), pc, ra, rb, 1'b0);
    check_equal(alu_operator, op, "alu_operator_o");
    check_operands(ra, rb);
    check_equal(rf_raddr_a, rs1, "rf_raddr_a_o");
    check_equal(rf_raddr_b, rs2, "rf_raddr_b_o");
    check_equal(rf_waddr, rd, "rf_waddr_o");
    check_equal({rf_ren_a, rf_ren_b}, 2'b11, "read enables");
    check_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    go_idle();
  endtask

  task automatic test_addi_negative();
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc, r;
    int imm;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    r   = next_rand();
    imm = -1 - int'(r[10:0]);
    apply_instr(enc_i(imm, rs1, 3'b000, rd, opc_op_imm), pc, ra, rb, 1'b0);
    check_equal(alu_operator, id_pkg::alu_add, "alu_operator_o");
    check_operands(ra, imm);
    check_equal(rf_raddr_a, rs1, "rf_raddr_a_o");
    check_equal(rf_waddr, rd, "rf_waddr_o");
    check_equal({rf_ren_a, rf_ren_b}, 2'b10, "read enables");
    check_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    go_idle();
  endtask

  task automatic test_upper(input logic is_auipc);
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc, r;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    r = next_rand();
    apply_instr({r[19:0], rd, is_auipc ? opc_auipc : opc_lui}, pc, ra, rb, 1'b0);
    check_operands(is_auipc ? pc : 32'h0, {r[19:0], 12'h000});
    check_equal(rf_waddr, rd, "rf_waddr_o");
    check_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    go_idle();
  endtask

  task automatic test_mem(input logic is_store, input logic [2:0] f3,
                          input id_pkg::lsu_type_e size, input logic sext);
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc, r;
    int imm;
    int delay;
    int cycles;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    r     = next_rand();
    imm   = $signed(r[11:0]);
    delay = int'(r[31:16] % 6);
    apply_instr(is_store ? enc_s(imm, rs2, rs1, f3) : enc_i(imm, rs1, f3, rd, opc_load),
                pc, ra, rb, 1'b0);
    // Request cycle always stalls
    check_ctrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    check_equal(lsu_we, is_store, "lsu_we_o");
    check_equal(lsu_type, size, "lsu_type_o");
    if (!is_store) begin
      check_equal(lsu_sign_ext, sext, "lsu_sign_ext_o");
    end
    check_operands(ra, imm);
    check_equal(lsu_wdata, rb, "lsu_wdata_o");
    wait_for_done(delay, cycles);
    check_equal(cycles, delay + 1, "cycles until load/store done");
    check_ctrl(1'b1, !is_store, 1'b0, 1'b0, 1'b0);
    check_operands(ra, imm);
    go_idle();
  endtask

  task automatic test_branch(input logic [2:0] f3, input id_pkg::alu_op_e op,
                             input logic taken);
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc, r;
    int imm;
    int cycles;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    r   = next_rand();
    imm = $signed({r[11:0], 1'b0});
    apply_instr(enc_b(imm, rs2, rs1, f3), pc, ra, rb, taken);
    // First cycle compares the registers
    check_equal(alu_operator, op, "alu_operator_o");
    check_operands(ra, rb);
    check_equal({rf_ren_a, rf_ren_b}, 2'b11, "read enables");
    check_ctrl(!taken, 1'b0, 1'b0, 1'b0, 1'b0);
    if (taken) begin
      wait_for_done(-1, cycles);
      check_equal(cycles, 1, "cycles until branch done");
      check_equal(alu_operator, id_pkg::alu_add, "alu_operator_o target");
      check_operands(pc, imm);
      check_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    end
    go_idle();
  endtask

  task automatic test_jump(input logic is_jalr);
    logic [4:0] rs1, rs2, rd;
    logic [31:0] ra, rb, pc, r;
    int imm;
    int cycles;
    pick_operands(rs1, rs2, rd, ra, rb, pc);
    r = next_rand();
    if (is_jalr) begin
      imm = $signed(r[11:0]);
      apply_instr(enc_i(imm, rs1, 3'b000, rd, opc_jalr), pc, ra, rb, 1'b0);
      check_operands(ra, imm);
    end else begin
      imm = $signed({r[19:0], 1'b0});
      apply_instr(enc_j(imm, rd), pc, ra, rb, 1'b0);
      check_operands(pc, imm);
    end
    check_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    // Second cycle writes the link address
    wait_for_done(-1, cycles);
    check_equal(cycles, 1, "cycles until jump done");
    check_operands(pc, `ID_LINK_INCR);
    check_equal(rf_waddr, rd, "rf_waddr_o");
    check_ctrl(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    go_idle();
  endtask

  task automatic test_illegal(input logic [31:0] word);
    apply_instr(word, 32'h0000_0100, 32'h0, 32'h0, 1'b0);
    check_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    check_equal({rf_ren_a, rf_ren_b}, 2'b00, "read enables");
    go_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state       = 32'd30;
    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    instr_rdata     = '0;
    pc_id           = '0;
    branch_decision = 1'b0;
    lsu_resp_valid  = 1'b0;
    rf_rdata_a      = '0;
    rf_rdata_b      = '0;

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle();

    test_reg_reg(7'b0000000, 3'b000, id_pkg::alu_add);
    test_reg_reg(7'b0100000, 3'b000, id_pkg::alu_sub);
    test_reg_reg(7'b0000000, 3'b100, id_pkg::alu_xor);
    test_reg_reg(7'b0000000, 3'b010, id_pkg::alu_slt);
    test_reg_reg(7'b0000000, 3'b001, id_pkg::alu_sll);
    test_addi_negative();
    test_upper(1'b0);
    test_upper(1'b1);
    test_mem(1'b0, 3'b000, id_pkg::lsu_byte, 1'b1);
    test_mem(1'b0, 3'b101, id_pkg::lsu_half, 1'b0);
    test_mem(1'b0, 3'b010, id_pkg::lsu_word, 1'b1);
    test_mem(1'b1, 3'b010, id_pkg::lsu_word, 1'b0);
    test_branch(3'b000, id_pkg::alu_eq, 1'b0);
    test_branch(3'b100, id_pkg::alu_lt, 1'b1);
    test_branch(3'b111, id_pkg::alu_geu, 1'b1);
    test_jump(1'b0);
    test_jump(1'b1);
    // All-zero word and a multiply from the M extension
    test_illegal(32'h0000_0000);
    test_illegal(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3));
    go_idle();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* files.f */
+incdir+verilog
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_operand_mux.sv
verilog/id_ex_fsm.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/id_pkg.sv
      - verilog/id_decoder.sv
      - verilog/id_operand_mux.sv
      - verilog/id_ex_fsm.sv
      - verilog/id_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_id_stage.sv
